/* project.f */
+incdir+source
+incdir+bench
source/loader_pkg.sv
source/mem_write_if.sv
source/uart_receiver.sv
source/word_assembler.sv
source/load_sequencer.sv
source/strobe_divider.sv
source/program_memory.sv
source/little_loader_top.sv
bench/loader_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := loader_tb
FILELIST   := project.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)
PASS_TEXT  := SIMULATION PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/loader_tb_tasks.svh */
// all tasks return 2 ns after a rising edge, where inputs are driven

task automatic next_cycle();
    @(posedge sysclk);
    #2;
endtask

task automatic wait_cycles(input int count);
    int done;
    for (done = 0; done < count; done++) begin
        next_cycle();
    end
endtask

task automatic wait_mode(input mode_t target, input int limit);
    int waited;
    waited = 0;
    while (mode !== target && waited < limit) begin
        next_cycle();
        waited++;
    end
    if (mode !== target) begin
        error_count++;
        $display("timeout in %s: mode never reached %s within %0d cycles",
                 test_name, target.name(), limit);
    end
endtask

task automatic wait_count(input addr_t target, input int limit);
    int waited;
    waited = 0;
    while (word_count !== target && waited < limit) begin
        next_cycle();
        waited++;
    end
    if (word_count !== target) begin
        error_count++;
        $display("timeout in %s: word count never reached %0d within %0d cycles",
                 test_name, target, limit);
    end
endtask

// 8N1 frame, lsb first, then one idle bit time
task automatic send_byte(input logic [7:0] value);
    int bit_pos;
    uart_rx = 1'b0;
    wait_cycles(`CLKS_PER_BIT);
    for (bit_pos = 0; bit_pos < 8; bit_pos++) begin
        uart_rx = value[bit_pos];
        wait_cycles(`CLKS_PER_BIT);
    end
    uart_rx = 1'b1;
    wait_cycles(2 * `CLKS_PER_BIT);
endtask

task automatic read_word(input addr_t addr, output word_t data);
    read_addr = addr;
    next_cycle();
    data = read_data;
endtask

/* bench/loader_tb.sv */
`timescale 1ns/100ps
`include "loader_params.svh"

module loader_tb;
    import loader_pkg::*;

    logic   sysclk;
    logic   sysrst;
    logic   uart_rx;
    logic   load_switch;
    addr_t  read_addr;
    word_t  read_data;
    mode_t  mode;
    addr_t  word_count;
    logic   mem_ready;
    logic   pix_stb;
    logic   slow_stb;

    integer seed;
    int     error_count;
    int     tests_run;
    int     tests_failed;
    int     errors_at_start;
    string  test_name;
    word_t  loaded_words [8];
    word_t  dropped_words [2];
    word_t  new_word;
    word_t  read_back;
    logic   pix_hist [128];
    logic   slow_hist [128];
    int     i;
    int     j;
    int     ones;

    little_loader_top little_loader_top_inst (
        .sysclk      (sysclk),
        .sysrst      (sysrst),
        .uart_rx     (uart_rx),
        .load_switch (load_switch),
        .read_addr   (read_addr),
        .read_data   (read_data),
        .mode        (mode),
        .word_count  (word_count),
        .mem_ready   (mem_ready),
        .pix_stb     (pix_stb),
        .slow_stb    (slow_stb)
    );

    always #20 sysclk = ~sysclk;

    // strobes are registered, so they settle one clock after the mode
    assert property (@(posedge sysclk) disable iff (!sysrst)
        (mode != MODE_RUN) |=> (!pix_stb && !slow_stb))
    else begin
        error_count++;
        $display("strobe active outside run mode at %0t", $time);
    end

    assert property (@(posedge sysclk) disable iff (!sysrst) mem_ready |=> mem_ready)
    else begin
        error_count++;
        $display("memory ready dropped after rising at %0t", $time);
    end

    `include "loader_tb_tasks.svh"

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            error_count++;
            $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = error_count;
        tests_run++;
    endtask

    task automatic end_test();
        if (error_count != errors_at_start) begin
            tests_failed++;
            $display("test %s failed", test_name);
        end else begin
            $display("test %s ok", test_name);
        end
    endtask

    initial begin
        sysclk = 1'b0;
        sysrst = 1'b0;
        uart_rx = 1'b1;
        load_switch = 1'b0;
        read_addr = '0;
        seed = 18919;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (10) @(posedge sysclk);
        #2;
        sysrst = 1'b1;

        start_test("reset_to_run");
        check_value("mode after reset", 32'(MODE_RESET), 32'(mode));
        check_value("ready after reset", 0, 32'(mem_ready));
        check_value("strobes after reset", 0, 32'({pix_stb, slow_stb}));
        wait_mode(MODE_RUN, 4 * `MEM_INIT_CYCLES);
        check_value("ready in run", 1, 32'(mem_ready));
        end_test();

        start_test("run_strobes");
        wait_cycles(4);
        for (i = 0; i < 128; i++) begin
            pix_hist[i] = pix_stb;
            slow_hist[i] = slow_stb;
            next_cycle();
        end
        for (i = 1; i < 128; i++) begin
            check_value("pix toggle", 32'(!pix_hist[i-1]), 32'(pix_hist[i]));
        end
        // every 64 clock window holds one slow strobe
        for (i = 0; i <= 64; i++) begin
            ones = 0;
            for (j = i; j < i + 64; j++) begin
                ones += int'(slow_hist[j]);
            end
            check_value("slow strobes per window", 1, 32'(ones));
        end
        end_test();

        start_test("enter_load");
        load_switch = 1'b1;
        wait_mode(MODE_LOAD, 4 * `LOAD_FILTER_DEPTH);
        check_value("count at load", 0, 32'(word_count));
        next_cycle();
        check_value("strobes in load", 0, 32'({pix_stb, slow_stb}));
        end_test();

        start_test("load_words");
        for (i = 0; i < 8; i++) begin
            loaded_words[i] = word_t'($random(seed));
            send_byte(loaded_words[i][15:8]);
            send_byte(loaded_words[i][7:0]);
            wait_count(addr_t'(i + 1), 40);
        end
        load_switch = 1'b0;
        wait_mode(MODE_RUN, 4 * `LOAD_FILTER_DEPTH);
        check_value("count after load", 8, 32'(word_count));
        for (i = 0; i < 8; i++) begin
            read_word(addr_t'(i), read_back);
            check_value("loaded word", 32'(loaded_words[i]), 32'(read_back));
        end
        end_test();

        start_test("run_drops_words");
        for (i = 0; i < 2; i++) begin
            dropped_words[i] = word_t'($random(seed));
            send_byte(dropped_words[i][15:8]);
            send_byte(dropped_words[i][7:0]);
        end
        wait_cycles(10);
        check_value("count in run", 8, 32'(word_count));
        for (i = 0; i < 8; i++) begin
            read_word(addr_t'(i), read_back);
            check_value("word kept", 32'(loaded_words[i]), 32'(read_back));
        end
        // a stray write would land at the next free address
        read_word(addr_t'(8), read_back);
        assert (read_back !== dropped_words[0] && read_back !== dropped_words[1])
        else begin
            error_count++;
            $display("%s: a word sent in run mode was written to address 8", test_name);
        end
        end_test();

        start_test("second_load");
        new_word = word_t'($random(seed));
        if (new_word == loaded_words[0]) begin
            new_word = ~new_word;
        end
        load_switch = 1'b1;
        wait_mode(MODE_LOAD, 4 * `LOAD_FILTER_DEPTH);
        check_value("count restart", 0, 32'(word_count));
        send_byte(new_word[15:8]);
        send_byte(new_word[7:0]);
        wait_count(addr_t'(1), 40);
        load_switch = 1'b0;
        wait_mode(MODE_RUN, 4 * `LOAD_FILTER_DEPTH);
        check_value("count after reload", 1, 32'(word_count));
        read_word(addr_t'(0), read_back);
        check_value("address 0 overwritten", 32'(new_word), 32'(read_back));
        read_word(addr_t'(7), read_back);
        check_value("address 7 kept", 32'(loaded_words[7]), 32'(read_back));
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* source/little_loader_top.sv */
`timescale 1ns/100ps

module little_loader_top (
    input  logic              sysclk,
    input  logic              sysrst,
    input  logic              uart_rx,
    input  logic              load_switch,
    input  loader_pkg::addr_t read_addr,
    output loader_pkg::word_t read_data,
    output loader_pkg::mode_t mode,
    output loader_pkg::addr_t word_count,
    output logic              mem_ready,
    output logic              pix_stb,
    output logic              slow_stb
);
    import loader_pkg::*;

    logic [7:0] byte_data;
    logic       byte_valid;
    word_t      word_data;
    logic       word_valid;

    mem_write_if mem_bus ();

    assign mem_ready = mem_bus.ready;

    uart_receiver uart_receiver_inst (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .rx         (uart_rx),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    word_assembler word_assembler_inst (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .word_data  (word_data),
        .word_valid (word_valid)
    );

    load_sequencer load_sequencer_inst (
        .sysclk      (sysclk),
        .sysrst      (sysrst),
        .load_switch (load_switch),
        .word_data   (word_data),
        .word_valid  (word_valid),
        .mem         (mem_bus.sequencer),
        .mode        (mode),
        .word_count  (word_count)
    );

    strobe_divider strobe_divider_inst (
        .sysclk   (sysclk),
        .sysrst   (sysrst),
        .mode     (mode),
        .pix_stb  (pix_stb),
        .slow_stb (slow_stb)
    );

    program_memory program_memory_inst (
        .sysclk    (sysclk),
        .sysrst    (sysrst),
        .mem       (mem_bus.memory),
        .read_addr (read_addr),
        .read_data (read_data)
    );

endmodule

/* source/program_memory.sv */
`timescale 1ns/100ps
`include "loader_params.svh"

module program_memory (
    input  logic              sysclk,
    input  logic              sysrst,
    mem_write_if.memory       mem,
    input  loader_pkg::addr_t read_addr,
    output loader_pkg::word_t read_data
);
    import loader_pkg::*;

    localparam int DEPTH = 1 << `ADDR_WIDTH;
    localparam int INIT_CYCLES = `MEM_INIT_CYCLES;
    localparam int INIT_WIDTH = $clog2(INIT_CYCLES + 1);
    localparam logic [INIT_WIDTH-1:0] INIT_LAST = INIT_WIDTH'(INIT_CYCLES - 1);

    word_t                 ram [DEPTH];
    logic [INIT_WIDTH-1:0] init_count;

    // stand-in for the external memory start-up wait
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            init_count <= '0;
            mem.ready  <= 1'b0;
        end else if (!mem.ready) begin
            if (init_count == INIT_LAST) begin
                mem.ready <= 1'b1;
            end else begin
                init_count <= init_count + 1'b1;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (mem.write_en) begin
            ram[mem.addr] <= mem.data;
        end
    end

    // check port, data one clock after the address
    always_ff @(posedge sysclk) begin
        read_data <= ram[read_addr];
    end

endmodule

/* source/strobe_divider.sv */
`timescale 1ns/100ps
`include "loader_params.svh"

module strobe_divider (
    input  logic              sysclk,
    input  logic              sysrst,
    input  loader_pkg::mode_t mode,
    output logic              pix_stb,
    output logic              slow_stb
);
    import loader_pkg::*;

    localparam int ACC_WIDTH = 16;
    localparam logic [ACC_WIDTH:0] PIX_STEP = (ACC_WIDTH + 1)'(`PIX_INCREMENT);
    localparam logic [ACC_WIDTH:0] SLOW_STEP = (ACC_WIDTH + 1)'(`SLOW_INCREMENT);
    localparam logic [ACC_WIDTH-1:0] SLOW_START = ACC_WIDTH'(`SLOW_PRESET);

    logic [ACC_WIDTH-1:0] pix_acc;
    logic [ACC_WIDTH-1:0] slow_acc;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            pix_acc  <= '0;
            slow_acc <= SLOW_START;
            pix_stb  <= 1'b0;
            slow_stb <= 1'b0;
        end else if (mode == MODE_RUN) begin
            // strobe is the carry out of each accumulator
            {pix_stb, pix_acc}   <= {1'b0, pix_acc} + PIX_STEP;
            {slow_stb, slow_acc} <= {1'b0, slow_acc} + SLOW_STEP;
        end else begin
            // accumulators hold their phase
            pix_stb  <= 1'b0;
            slow_stb <= 1'b0;
        end
    end

endmodule

/* source/load_sequencer.sv */
`timescale 1ns/100ps
`include "loader_params.svh"

module load_sequencer (
    input  logic              sysclk,
    input  logic              sysrst,
    input  logic              load_switch,
    input  loader_pkg::word_t word_data,
    input  logic              word_valid,
    mem_write_if.sequencer    mem,
    output loader_pkg::mode_t mode,
    output loader_pkg::addr_t word_count
);
    import loader_pkg::*;

    localparam int FILTER_DEPTH = `LOAD_FILTER_DEPTH;
    localparam logic [FILTER_DEPTH-1:0] FILTER_HIGH = {FILTER_DEPTH{1'b1}};
    localparam logic [FILTER_DEPTH-1:0] FILTER_LOW = {FILTER_DEPTH{1'b0}};
    // newest samples high, oldest still low
    localparam logic [FILTER_DEPTH-1:0] FILTER_RISE = {1'b0, {(FILTER_DEPTH - 1){1'b1}}};

    mode_t                   next_mode;
    logic [FILTER_DEPTH-1:0] load_samples;
    logic [1:0]              valid_hist;
    logic                    load_word;

    // words outside load mode are dropped here
    assign load_word = word_valid && (mode == MODE_LOAD);

    always_comb begin
        next_mode = mode;
        case (mode)
            MODE_RESET: begin
                if (mem.ready) begin
                    next_mode = MODE_RUN;
                end
            end
            MODE_RUN: begin
                if (load_samples == FILTER_HIGH) begin
                    next_mode = MODE_LOAD;
                end
            end
            MODE_LOAD: begin
                if (load_samples == FILTER_LOW) begin
                    next_mode = MODE_RUN;
                end
            end
            default: next_mode = MODE_RESET;
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            mode         <= MODE_RESET;
            load_samples <= '0;
            valid_hist   <= '0;
            word_count   <= '0;
            mem.write_en <= 1'b0;
        end else begin
            mode         <= next_mode;
            load_samples <= {load_samples[FILTER_DEPTH-2:0], load_switch};
            valid_hist   <= {valid_hist[0], load_word};
            mem.write_en <= load_word;
            // a fresh load starts at address zero
            if (load_samples == FILTER_RISE) begin
                word_count <= '0;
            end else if (valid_hist == 2'b10) begin
                // falling edge of word valid, after the write used the old count
                word_count <= word_count + addr_t'(1);
            end
        end
    end

    // write address and data line up with the write pulse
    always_ff @(posedge sysclk) begin
        mem.addr <= word_count;
        mem.data <= word_data;
    end

endmodule

/* source/word_assembler.sv */
`timescale 1ns/100ps

module word_assembler (
    input  logic              sysclk,
    input  logic              sysrst,
    input  logic [7:0]        byte_data,
    input  logic              byte_valid,
    output loader_pkg::word_t word_data,
    output logic              word_valid
);
    // set while waiting for the low byte
    logic       have_high;
    logic [7:0] high_byte;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            have_high  <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (byte_valid) begin
                if (have_high) begin
                    have_high  <= 1'b0;
                    word_valid <= 1'b1;
                end else begin
                    have_high <= 1'b1;
                end
            end
        end
    end

    // first byte of a pair is the high half
    always_ff @(posedge sysclk) begin
        if (byte_valid) begin
            if (have_high) begin
                word_data <= {high_byte, byte_data};
            end else begin
                high_byte <= byte_data;
            end
        end
    end

endmodule

/* source/uart_receiver.sv */
`timescale 1ns/100ps
`include "loader_params.svh"

module uart_receiver (
    input  logic       sysclk,
    input  logic       sysrst,
    input  logic       rx,
    output logic [7:0] byte_data,
    output logic       byte_valid
);
    localparam int BIT_CLKS = `CLKS_PER_BIT;
    localparam int TIMER_WIDTH = $clog2(BIT_CLKS);
    localparam logic [TIMER_WIDTH-1:0] FULL_BIT = TIMER_WIDTH'(BIT_CLKS - 1);
    localparam logic [TIMER_WIDTH-1:0] HALF_BIT = TIMER_WIDTH'(BIT_CLKS / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t              state;
    logic                   rx_meta;
    logic                   rx_sync;
    logic                   rx_prev;
    logic [TIMER_WIDTH-1:0] bit_timer;
    logic [2:0]             bit_index;
    logic [7:0]             shift_reg;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            // idle line is high
            rx_meta    <= 1'b1;
            rx_sync    <= 1'b1;
            rx_prev    <= 1'b1;
            state      <= RX_IDLE;
            bit_timer  <= '0;
            bit_index  <= '0;
            byte_valid <= 1'b0;
        end else begin
            rx_meta    <= rx;
            rx_sync    <= rx_meta;
            rx_prev    <= rx_sync;
            byte_valid <= 1'b0;
            bit_timer  <= bit_timer + 1'b1;
            case (state)
                RX_IDLE: begin
                    bit_timer <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // mid start bit, line must still be low
                    if (bit_timer == HALF_BIT) begin
                        bit_timer <= '0;
                        bit_index <= '0;
                        state     <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_timer == FULL_BIT) begin
                        bit_timer <= '0;
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    // drop the frame on a bad stop bit
                    if (bit_timer == FULL_BIT) begin
                        byte_valid <= rx_sync;
                        state      <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first, shift in from the top
    always_ff @(posedge sysclk) begin
        if (state == RX_DATA && bit_timer == FULL_BIT) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
        if (state == RX_STOP && bit_timer == FULL_BIT) begin
            byte_data <= shift_reg;
        end
    end

endmodule

/* source/mem_write_if.sv */
`timescale 1ns/100ps

interface mem_write_if;
    import loader_pkg::*;

    // one-cycle write strobe, no back-pressure
    logic  write_en;
    addr_t addr;
    word_t data;
    // level, high once memory init is done
    logic  ready;

    modport sequencer (
        output write_en,
        output addr,
        output data,
        input  ready
    );

    modport memory (
        input  write_en,
        input  addr,
        input  data,
        output ready
    );

endinterface

/* source/loader_pkg.sv */
`include "loader_params.svh"

package loader_pkg;

    // system modes
    typedef enum logic [1:0] {
        MODE_RESET = 2'd0,
        MODE_LOAD  = 2'd1,
        MODE_RUN   = 2'd2
    } mode_t;

    // one program memory word
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // one program memory address
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

endpackage

/* source/loader_params.svh */
`ifndef LOADER_PARAMS_SVH
`define LOADER_PARAMS_SVH

// memory geometry
`define WORD_WIDTH 16
`define ADDR_WIDTH 8

// serial line timing, kept short so simulation stays fast
`define CLKS_PER_BIT 8

// load switch debounce
`define LOAD_FILTER_DEPTH 8

// clocks before program memory reports ready
`define MEM_INIT_CYCLES 20

// phase accumulator steps, 16-bit accumulators
// pixel strobe divides by 2
`define PIX_INCREMENT 32768
// slow strobe divides by 64
`define SLOW_INCREMENT 1024
// slow accumulator start value, first carry two clocks into run
`define SLOW_PRESET 63488

`endif
